//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int TIMER_W_DEFAULT = 32;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN
    } csr_op_t;

    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [5:0] ECODE_ALE = 6'h09;
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_BRK = 6'h0c;

    localparam logic [8:0] CRMD_RESET = 9'h008; // DA=1, PLV0, IE=0

    typedef struct packed {
        logic        valid;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } excp_t;

    typedef struct packed {
        csr_op_t     op;
        logic [13:0] csr_num;
        logic [31:0] wdata;    // merged under mask
        logic [31:0] pc;
        logic        trap;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_req_t;

    typedef struct packed {
        logic [8:0]       crmd;
        logic [2:0]       prmd;
        logic [11:0]      ecfg_lie;       // bit 10 always zero
        logic [1:0]       estat_is;
        logic [5:0]       estat_ecode;
        logic [8:0]       estat_esubcode;
        logic [31:0]      era;
        logic [31:0]      badv;
        logic [25:0]      eentry;
        logic [3:0][31:0] save;
        logic [31:0]      tid;
    } csr_state_t;

    typedef struct packed {
        logic [TIMER_W_DEFAULT-1:0] tcfg;
        logic [TIMER_W_DEFAULT-1:0] tval;
        logic                       ti;
    } timer_state_t;

endpackage

`default_nettype wire

//--- logic/csr_issue.sv
`default_nettype none

module csr_issue (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    inst_valid,
    input  csr_pkg::csr_op_t        op,
    input  logic [13:0]             csr_num,
    input  logic [31:0]             wdata,
    input  logic [31:0]             wmask,
    input  logic [31:0]             pc,
    input  csr_pkg::excp_t          excp,
    input  logic [7:0]              hw_int,
    input  logic                    stall,
    input  logic                    flush,
    input  csr_pkg::csr_state_t     state,
    input  csr_pkg::timer_state_t   timer,
    output csr_pkg::csr_req_t       req,
    output logic                    req_valid,
    output logic [31:0]             rdata,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc
);

    logic [11:0] int_vec;
    logic        int_pend;
    logic        accept;
    logic        trap;
    logic        is_redir;
    logic [31:0] rd_val;
    logic [31:0] wmask_eff;
    logic [31:0] merged;

    // bit 10 reserved, bit 11 timer
    assign int_vec  = {timer.ti, 1'b0, hw_int, state.estat_is};
    // hold off while a redirect is in flight and IE is not yet cleared
    assign int_pend = (|(int_vec & state.ecfg_lie)) && state.crmd[2] && !redirect_valid;

    assign accept    = inst_valid && (op != csr_pkg::OP_NONE || excp.valid) && !stall && !flush;
    assign req_valid = int_pend || accept;
    assign trap      = int_pend || excp.valid;
    assign is_redir  = trap || op == csr_pkg::OP_ERTN;

    always_comb
    begin
        rd_val = '0;
        case (csr_num)
            csr_pkg::CSR_CRMD:   rd_val = {23'b0, state.crmd};
            csr_pkg::CSR_PRMD:   rd_val = {29'b0, state.prmd};
            csr_pkg::CSR_ECFG:   rd_val = {20'b0, state.ecfg_lie};
            csr_pkg::CSR_ESTAT:
                rd_val = {1'b0, state.estat_esubcode, state.estat_ecode, 4'b0,
                          timer.ti, 1'b0, hw_int, state.estat_is};
            csr_pkg::CSR_ERA:    rd_val = state.era;
            csr_pkg::CSR_BADV:   rd_val = state.badv;
            csr_pkg::CSR_EENTRY: rd_val = {state.eentry, 6'b0};
            csr_pkg::CSR_SAVE0:  rd_val = state.save[0];
            csr_pkg::CSR_SAVE1:  rd_val = state.save[1];
            csr_pkg::CSR_SAVE2:  rd_val = state.save[2];
            csr_pkg::CSR_SAVE3:  rd_val = state.save[3];
            csr_pkg::CSR_TID:    rd_val = state.tid;
            csr_pkg::CSR_TCFG:   rd_val = timer.tcfg;
            csr_pkg::CSR_TVAL:   rd_val = timer.tval;
            default:             rd_val = '0; // TICLR reads zero
        endcase
    end

    assign wmask_eff = (op == csr_pkg::OP_CSRWR) ? '1 : wmask;
    assign merged    = (rd_val & ~wmask_eff) | (wdata & wmask_eff);

    always_comb
    begin
        req.op       = trap ? csr_pkg::OP_NONE : op;
        req.csr_num  = csr_num;
        req.wdata    = merged;
        req.pc       = pc;
        req.trap     = trap;
        req.ecode    = int_pend ? csr_pkg::ECODE_INT : excp.ecode;
        req.esubcode = int_pend ? 9'd0 : excp.esubcode;
        req.badv     = excp.badv;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rdata          <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end
        else
        begin
            redirect_valid <= req_valid && is_redir; // pulses once per trap or ertn
            if (req_valid)
            begin
                rdata       <= rd_val;
                redirect_pc <= trap ? {state.eentry, 6'b0} : state.era;
            end
            else if (flush)
            begin
                rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_commit.sv
`default_nettype none

module csr_commit (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_pkg::csr_req_t     req,
    input  logic                  req_valid,
    output csr_pkg::csr_state_t   state,
    output logic [8:0]            crmd,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output logic                  tcfg_we,
    output logic [31:0]           tcfg_wdata,
    output logic                  ti_clr
);

    csr_pkg::csr_req_t   req_q;
    logic                valid_q;
    csr_pkg::csr_state_t st;
    logic                do_trap;
    logic                do_ertn;
    logic                csr_we;

    // stage register between issue and commit
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            req_q <= req;
        end
    end

    assign do_trap = valid_q && req_q.trap;
    assign do_ertn = valid_q && !req_q.trap && req_q.op == csr_pkg::OP_ERTN;
    assign csr_we  = valid_q && !req_q.trap &&
                     (req_q.op == csr_pkg::OP_CSRWR || req_q.op == csr_pkg::OP_CSRXCHG);

    // timer registers live in csr_timer
    assign tcfg_we    = csr_we && req_q.csr_num == csr_pkg::CSR_TCFG;
    assign tcfg_wdata = req_q.wdata;
    assign ti_clr     = csr_we && req_q.csr_num == csr_pkg::CSR_TICLR && req_q.wdata[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            st         <= '0;
            st.crmd    <= csr_pkg::CRMD_RESET;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= do_trap;
            ertn_flush <= do_ertn;
            if (do_trap)
            begin
                st.prmd           <= st.crmd[2:0]; // PLV and IE
                st.crmd[2:0]      <= 3'b0;
                st.era            <= req_q.pc;
                st.estat_ecode    <= req_q.ecode;
                st.estat_esubcode <= req_q.esubcode;
                if (req_q.ecode == csr_pkg::ECODE_ALE || req_q.ecode == csr_pkg::ECODE_ADE)
                begin
                    st.badv <= req_q.badv;
                end
            end
            else if (do_ertn)
            begin
                st.crmd[2:0] <= st.prmd;
            end
            else if (csr_we)
            begin
                case (req_q.csr_num)
                    csr_pkg::CSR_CRMD:   st.crmd     <= req_q.wdata[8:0];
                    csr_pkg::CSR_PRMD:   st.prmd     <= req_q.wdata[2:0];
                    csr_pkg::CSR_ECFG:
                        st.ecfg_lie <= {req_q.wdata[11], 1'b0, req_q.wdata[9:0]};
                    csr_pkg::CSR_ESTAT:  st.estat_is <= req_q.wdata[1:0]; // soft ints only
                    csr_pkg::CSR_ERA:    st.era      <= req_q.wdata;
                    csr_pkg::CSR_BADV:   st.badv     <= req_q.wdata;
                    csr_pkg::CSR_EENTRY: st.eentry   <= req_q.wdata[31:6];
                    csr_pkg::CSR_SAVE0:  st.save[0]  <= req_q.wdata;
                    csr_pkg::CSR_SAVE1:  st.save[1]  <= req_q.wdata;
                    csr_pkg::CSR_SAVE2:  st.save[2]  <= req_q.wdata;
                    csr_pkg::CSR_SAVE3:  st.save[3]  <= req_q.wdata;
                    csr_pkg::CSR_TID:    st.tid      <= req_q.wdata;
                    default:             ;
                endcase
            end
        end
    end

    assign state = st;
    assign crmd  = st.crmd;

endmodule

`default_nettype wire

//--- logic/csr_timer.sv
`default_nettype none

module csr_timer #(
    parameter int TIMER_W = csr_pkg::TIMER_W_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tcfg_we,
    input  logic [31:0]            tcfg_wdata,
    input  logic                   ti_clr,
    output csr_pkg::timer_state_t  timer
);

    logic [TIMER_W-1:0] tcfg_q;
    logic [TIMER_W-1:0] tval_q;
    logic [TIMER_W-1:0] init_val;
    logic               ti_q;
    logic               reload_q;

    // tcfg bit 0 enable, bit 1 periodic, upper bits initial value
    assign init_val = {tcfg_q[TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q   <= '0;
            tval_q   <= '0;
            ti_q     <= 1'b0;
            reload_q <= 1'b0;
        end
        else
        begin
            reload_q <= tcfg_we;
            if (tcfg_we)
            begin
                tcfg_q <= tcfg_wdata[TIMER_W-1:0];
            end
            if (reload_q)
            begin
                tval_q <= init_val; // cycle after the config write
            end
            else if (tcfg_q[0])
            begin
                if (tval_q != '0)
                    tval_q <= tval_q - 1'b1;
                else if (tcfg_q[1])
                    tval_q <= init_val;
            end
            if (ti_clr)
                ti_q <= 1'b0;
            else if (tcfg_q[0] && !reload_q && tval_q == TIMER_W'(1))
                ti_q <= 1'b1; // on reaching zero
        end
    end

    always_comb
    begin
        timer                   = '0;
        timer.tcfg[TIMER_W-1:0] = tcfg_q;
        timer.tval[TIMER_W-1:0] = tval_q;
        timer.ti                = ti_q;
    end

endmodule

`default_nettype wire

//--- logic/csr_top.sv
`default_nettype none

module csr_top #(
    parameter int TIMER_W = csr_pkg::TIMER_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              inst_valid,
    input  csr_pkg::csr_op_t  op,
    input  logic [13:0]       csr_num,
    input  logic [31:0]       wdata,
    input  logic [31:0]       wmask,
    input  logic [31:0]       pc,
    input  csr_pkg::excp_t    excp,
    input  logic [7:0]        hw_int,
    input  logic              stall,
    input  logic              flush,
    output logic [31:0]       rdata,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc,
    output logic              excp_flush,
    output logic              ertn_flush,
    output logic [8:0]        crmd
);

    csr_pkg::csr_req_t     req;
    logic                  req_valid;
    csr_pkg::csr_state_t   state;
    csr_pkg::timer_state_t timer;
    logic                  tcfg_we;
    logic [31:0]           tcfg_wdata;
    logic                  ti_clr;

    csr_issue u_issue (
        .clk            (clk),
        .rstn           (rstn),
        .inst_valid     (inst_valid),
        .op             (op),
        .csr_num        (csr_num),
        .wdata          (wdata),
        .wmask          (wmask),
        .pc             (pc),
        .excp           (excp),
        .hw_int         (hw_int),
        .stall          (stall),
        .flush          (flush),
        .state          (state),
        .timer          (timer),
        .req            (req),
        .req_valid      (req_valid),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_commit u_commit (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .req_valid  (req_valid),
        .state      (state),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .ti_clr     (ti_clr)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .ti_clr     (ti_clr),
        .timer      (timer)
    );

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/csr_properties.sv
`default_nettype none

module csr_properties (
    input logic clk,
    input logic rstn,
    input logic redirect_valid,
    input logic excp_flush,
    input logic ertn_flush
);

    int unsigned fail_cnt = 0;

    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
    else
    begin
        fail_cnt++;
        $error("excp_flush and ertn_flush high in the same cycle");
    end

    // redirect leads the flush by one cycle
    flush_after_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> $past(redirect_valid))
    else
    begin
        fail_cnt++;
        $error("flush pulse without redirect_valid one cycle earlier");
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> !(redirect_valid || excp_flush || ertn_flush))
    else
    begin
        fail_cnt++;
        $error("output pulse while reset is asserted");
    end

endmodule

bind csr_top csr_properties u_props (
    .clk            (clk),
    .rstn           (rstn),
    .redirect_valid (redirect_valid),
    .excp_flush     (excp_flush),
    .ertn_flush     (ertn_flush)
);

`default_nettype wire

//--- verif/csr_tb.sv
`default_nettype none

module csr_tb;

    localparam int          CLK_PERIOD = 4;
    localparam int          NUM_TESTS  = 6;
    localparam logic [31:0] TIMER_INIT = 32'h40;  // countdown start with low bits clear
    localparam int          TIMER_CYC  = 80;      // longest timer interval plus slack
    localparam int          MARGIN_CYC = 200;

    logic                clk;
    logic                rstn;
    logic                inst_valid;
    csr_pkg::csr_op_t    op;
    logic [13:0]         csr_num;
    logic [31:0]         wdata;
    logic [31:0]         wmask;
    logic [31:0]         pc;
    csr_pkg::excp_t      excp;
    logic [7:0]          hw_int;
    logic                stall;
    logic                flush;
    logic [31:0]         rdata;
    logic                redirect_valid;
    logic [31:0]         redirect_pc;
    logic                excp_flush;
    logic                ertn_flush;
    logic [8:0]          crmd;

    integer              seed;
    logic [31:0]         save_val [4];
    logic [31:0]         rd;
    logic [31:0]         old_val;
    logic [31:0]         new_val;
    logic [31:0]         mask_val;
    logic [31:0]         eentry_val;
    logic [31:0]         pc_val;
    logic                seen;
    csr_pkg::excp_t      sys_excp;
    logic [31:0]         got_rdata;
    logic                got_redir;
    logic [31:0]         got_redir_pc;
    logic                got_excp_flush;
    logic                got_ertn_flush;

    clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    csr_top #(
        .TIMER_W (csr_pkg::TIMER_W_DEFAULT)
    ) uut (
        .clk            (clk),
        .rstn           (rstn),
        .inst_valid     (inst_valid),
        .op             (op),
        .csr_num        (csr_num),
        .wdata          (wdata),
        .wmask          (wmask),
        .pc             (pc),
        .excp           (excp),
        .hw_int         (hw_int),
        .stall          (stall),
        .flush          (flush),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush),
        .crmd           (crmd)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // bitwise pick of the new bit where the mask is set
    function automatic logic [31:0] merge_under_mask(input logic [31:0] old_word,
                                                     input logic [31:0] new_word,
                                                     input logic [31:0] mask);
        logic [31:0] result;
        for (int b = 0; b < 32; b++)
        begin
            result[b] = mask[b] ? new_word[b] : old_word[b];
        end
        return result;
    endfunction

    // starts at a falling edge and samples the outputs of cycles N+1 and N+2
    task automatic issue_request(input csr_pkg::csr_op_t req_op, input logic [13:0] num,
                                 input logic [31:0] data, input logic [31:0] mask,
                                 input csr_pkg::excp_t e);
        inst_valid = 1'b1;
        op         = req_op;
        csr_num    = num;
        wdata      = data;
        wmask      = mask;
        excp       = e;
        @(negedge clk);
        got_rdata    = rdata;
        got_redir    = redirect_valid;
        got_redir_pc = redirect_pc;
        inst_valid   = 1'b0;
        op           = csr_pkg::OP_NONE;
        excp         = '0;
        @(negedge clk);
        got_excp_flush = excp_flush;
        got_ertn_flush = ertn_flush;
    endtask

    task automatic read_csr(input logic [13:0] num, output logic [31:0] value);
        issue_request(csr_pkg::OP_CSRRD, num, '0, '0, '0);
        value = got_rdata;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data);
        issue_request(csr_pkg::OP_CSRWR, num, data, '0, '0);
    endtask

    task automatic exchange_csr(input logic [13:0] num, input logic [31:0] data,
                                input logic [31:0] mask, output logic [31:0] old);
        issue_request(csr_pkg::OP_CSRXCHG, num, data, mask, '0);
        old = got_rdata;
    endtask

    task automatic wait_for_redirect(input int max_cycles, output logic found);
        found = 1'b0;
        for (int i = 0; i < max_cycles && !found; i++)
        begin
            @(negedge clk);
            found = redirect_valid;
        end
    endtask

    initial
    begin
        seed       = 32'h4245_3352;
        rstn       = 1'b0;
        inst_valid = 1'b0;
        op         = csr_pkg::OP_NONE;
        csr_num    = '0;
        wdata      = '0;
        wmask      = '0;
        pc         = '0;
        excp       = '0;
        hw_int     = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        check_value("reset crmd", 32'(csr_pkg::CRMD_RESET), 32'(crmd));
        check_value("reset rdata", 32'h0, rdata);
        read_csr(csr_pkg::CSR_CRMD, rd);
        check_value("reset read crmd", 32'h8, rd);

        for (int i = 0; i < 4; i++)
        begin
            save_val[i] = $random(seed);
            write_csr(csr_pkg::CSR_SAVE0 + 14'(i), save_val[i]);
        end
        for (int i = 0; i < 4; i++)
        begin
            read_csr(csr_pkg::CSR_SAVE0 + 14'(i), rd);
            check_value("save readback", save_val[i], rd);
        end
        new_val  = $random(seed);
        mask_val = $random(seed);
        exchange_csr(csr_pkg::CSR_SAVE1, new_val, mask_val, old_val);
        check_value("xchg old value", save_val[1], old_val);
        read_csr(csr_pkg::CSR_SAVE1, rd);
        check_value("xchg merge", merge_under_mask(save_val[1], new_val, mask_val), rd);

        eentry_val = $random(seed) & 32'hffff_ffc0; // 64-byte aligned entry
        pc_val     = $random(seed) & 32'hffff_fffc;
        write_csr(csr_pkg::CSR_EENTRY, eentry_val);
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_000b);  // DA, PLV3, IE off
        sys_excp       = '0;
        sys_excp.valid = 1'b1;
        sys_excp.ecode = csr_pkg::ECODE_SYS;
        pc             = pc_val;
        issue_request(csr_pkg::OP_NONE, '0, '0, '0, sys_excp);
        check_value("syscall redirect valid", 32'h1, 32'(got_redir));
        check_value("syscall redirect pc", eentry_val, got_redir_pc);
        check_value("syscall excp_flush", 32'h1, 32'(got_excp_flush));
        read_csr(csr_pkg::CSR_ERA, rd);
        check_value("syscall era", pc_val, rd);
        read_csr(csr_pkg::CSR_ESTAT, rd);
        check_value("syscall ecode", 32'(csr_pkg::ECODE_SYS), 32'(rd[21:16]));
        read_csr(csr_pkg::CSR_PRMD, rd);
        check_value("syscall prmd", 32'h3, rd);
        check_value("syscall crmd low bits", 32'h0, 32'(crmd[2:0]));

        issue_request(csr_pkg::OP_ERTN, '0, '0, '0, '0);
        check_value("ertn redirect valid", 32'h1, 32'(got_redir));
        check_value("ertn redirect pc", pc_val, got_redir_pc);
        check_value("ertn flush", 32'h1, 32'(got_ertn_flush));
        check_value("ertn crmd", 32'h0000_000b, 32'(crmd));

        write_csr(csr_pkg::CSR_ECFG, 32'h0000_0800);    // timer line only
        write_csr(csr_pkg::CSR_TCFG, TIMER_INIT | 32'h3); // periodic, enabled
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_000c);
        wait_for_redirect(TIMER_CYC, seen);
        assert (seen)
        else
        begin
            $display("timer interrupt did not trap within the timer interval");
            $display("TESTS FAILED");
            $fatal(1, "no timer interrupt");
        end
        check_value("timer int redirect pc", eentry_val, redirect_pc);
        @(negedge clk);
        check_value("timer int excp_flush", 32'h1, 32'(excp_flush));
        check_value("timer int clears ie", 32'h0, 32'(crmd[2]));
        read_csr(csr_pkg::CSR_ESTAT, rd);
        check_value("timer int ecode", 32'(csr_pkg::ECODE_INT), 32'(rd[21:16]));
        check_value("timer int estat ti", 32'h1, 32'(rd[11]));
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT, rd);
        check_value("ticlr estat ti", 32'h0, 32'(rd[11]));
        write_csr(csr_pkg::CSR_TCFG, 32'h0);

        read_csr(csr_pkg::CSR_SAVE0, rd);
        stall      = 1'b1;
        inst_valid = 1'b1;
        op         = csr_pkg::OP_CSRRD;
        csr_num    = csr_pkg::CSR_SAVE2;
        repeat (3)
        begin
            @(negedge clk);
            check_value("stall holds rdata", save_val[0], rdata);
        end
        stall = 1'b0;
        @(negedge clk);
        check_value("read after stall", save_val[2], rdata);
        inst_valid = 1'b0;
        op         = csr_pkg::OP_NONE;
        @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

    initial
    begin
        wait (uut.u_props.fail_cnt != 0);
        $display("a protocol assertion on the redirect and flush outputs failed");
        $display("TESTS FAILED");
        $fatal(1, "protocol assertion failure");
    end

    initial
    begin
        #((NUM_TESTS * TIMER_CYC + MARGIN_CYC) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- compile.f
logic/csr_pkg.sv
logic/csr_issue.sv
logic/csr_commit.sv
logic/csr_timer.sv
logic/csr_top.sv
verif/clk_gen.sv
verif/csr_properties.sv
verif/csr_tb.sv

//--- Makefile
# Verilator build and run for the CSR unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module csr_tb -Mdir obj_dir -f compile.f

run: compile
	-./obj_dir/Vcsr_tb > sim.log 2>&1
	cat sim.log
	grep -qx "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
